// ==== src/rv_pkg.sv ====
// RV32I pipeline shared definitions
// Widths, instruction and ALU encodings, forwarding selects and the
// structs carried between the five pipeline stages
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // Word index from byte address bits 9:2

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // ADDI x0, x0, 0

    // ==============================
    // Encodings
    // ==============================
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // Value read in decode
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    // ==============================
    // Pipeline registers
    // ==============================
    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic     alu_src;     // Immediate as operand B
        logic     mem_write;
        logic     mem_to_reg;  // Set only for loads
        logic     reg_write;
        logic     branch;
        logic     branch_ne;   // BNE when set, BEQ otherwise
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_write;
        logic     mem_to_reg;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_to_reg;
    } mem_wb_t;

    // Retire strobe, one cycle per register write
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_event_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic fetch_hold;
        logic flush_if_id;
        logic bubble_id_ex;
    } pipe_ctl_t;

endpackage

// ==== src/fetch_unit.sv ====
// Fetch stage
// Program counter with branch redirect and hold, plus the IF/ID register
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::pipe_ctl_t ctl,
    input  rv_pkg::redirect_t redirect,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::if_id_t    if_id
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_next;

    always_comb begin
        if (redirect.taken) begin
            pc_next = redirect.target;  // Taken branch beats a hold
        end else if (ctl.fetch_hold) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;

    // IF/ID register, flushed slot becomes a NOP
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id <= '{pc: '0, instr: NOP_INSTR};
        end else if (ctl.flush_if_id) begin
            if_id <= '{pc: '0, instr: NOP_INSTR};
        end else if (!ctl.fetch_hold) begin
            if_id <= '{pc: pc, instr: imem_data};
        end
    end

endmodule

// ==== src/decode_unit.sv ====
// Decode stage
// Main decoder, ALU operation select and I/S/B immediate build.
// Loads the ID/EX register, or a bubble on stall or flush
`timescale 1ns/1ps

module decode_unit (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::if_id_t    if_id,
    input  rv_pkg::pipe_ctl_t ctl,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::reg_idx_t  rs1_idx,
    output rv_pkg::reg_idx_t  rs2_idx,
    output rv_pkg::id_ex_t    id_ex
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    alu_op_e    arith_op;
    id_ex_t     dec;  // Next contents of ID/EX

    assign opcode  = opcode_e'(if_id.instr[6:0]);
    assign funct3  = if_id.instr[14:12];
    assign funct7  = if_id.instr[31:25];
    assign rs1_idx = if_id.instr[19:15];
    assign rs2_idx = if_id.instr[24:20];

    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                    if_id.instr[30:25], if_id.instr[11:8], 1'b0};

    // ALU op for OP and OP_IMM, no SUBI in the immediate form
    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == OP && funct7[5]) ? SUB : ADD;
            3'b001: arith_op = SLL;
            3'b010: arith_op = SLT;
            3'b011: arith_op = SLTU;
            3'b100: arith_op = XOR;
            3'b101: arith_op = funct7[5] ? SRA : SRL;  // Same bit for SRAI
            3'b110: arith_op = OR;
            3'b111: arith_op = AND;
        endcase
    end

    always_comb begin
        dec         = '0;
        dec.pc      = if_id.pc;
        dec.rs1_val = rs1_data;
        dec.rs2_val = rs2_data;
        dec.rs1     = rs1_idx;
        dec.rs2     = rs2_idx;
        dec.rd      = if_id.instr[11:7];
        dec.alu_op  = ADD;  // Address add for loads and stores
        case (opcode)
            OP: begin
                dec.alu_op    = arith_op;
                dec.reg_write = 1'b1;
            end
            OP_IMM: begin
                dec.alu_op    = arith_op;
                dec.alu_src   = 1'b1;
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
            end
            LOAD: begin
                dec.alu_src    = 1'b1;
                dec.imm        = imm_i;
                dec.reg_write  = 1'b1;
                dec.mem_to_reg = 1'b1;
            end
            STORE: begin
                dec.alu_src   = 1'b1;
                dec.imm       = imm_s;
                dec.mem_write = 1'b1;
            end
            BRANCH: begin
                dec.alu_op    = SUB;  // Zero result means equal
                dec.imm       = imm_b;
                dec.branch    = 1'b1;
                dec.branch_ne = funct3[0];
            end
            default: begin
                dec.reg_write = 1'b0;  // Unsupported opcode runs as a bubble
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (ctl.bubble_id_ex) begin
            id_ex <= '0;
        end else begin
            id_ex <= dec;
        end
    end

endmodule

// ==== src/reg_file.sv ====
// Integer register file
// 31 writable registers, x0 reads as zero, same-cycle write is
// bypassed to both read ports
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_idx_t  rs1_idx,
    input  rv_pkg::reg_idx_t  rs2_idx,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  rv_pkg::wb_event_t wb
);
    import rv_pkg::*;

    word_t regs [1:2**REG_ADDR_W-1];

    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.valid && wb.rd == idx) begin
            return wb.data;  // Write-first
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// ==== src/execute_unit.sv ====
// Execute stage
// Operand forwarding, immediate select, ALU, BEQ/BNE resolution
// and the EX/MEM register
`timescale 1ns/1ps

module execute_unit (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::fwd_sel_e  fwd_a,
    input  rv_pkg::fwd_sel_e  fwd_b,
    output rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::mem_wb_t   mem_wb,
    input  rv_pkg::word_t     wb_data,
    output rv_pkg::redirect_t redirect
);
    import rv_pkg::*;

    word_t wb_fwd;
    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_result;
    logic  alu_zero;

    // ALU results skip the writeback mux, loads go through it
    assign wb_fwd = mem_wb.mem_to_reg ? wb_data : mem_wb.alu_result;

    // ==============================
    // Operand select
    // ==============================
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = ex_mem.alu_result;
            FWD_WB:  op_a = wb_fwd;
            default: op_a = id_ex.rs1_val;
        endcase
        case (fwd_b)
            FWD_MEM: rs2_fwd = ex_mem.alu_result;
            FWD_WB:  rs2_fwd = wb_fwd;
            default: rs2_fwd = id_ex.rs2_val;
        endcase
    end

    assign op_b = id_ex.alu_src ? id_ex.imm : rs2_fwd;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (id_ex.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << op_b[4:0];
            SLT:     alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> op_b[4:0];
            SRA:     alu_result = $signed(op_a) >>> op_b[4:0];
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            default: alu_result = '0;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    // Branch taken when zero disagrees with the NE flag
    assign redirect.taken  = id_ex.branch & (alu_zero ^ id_ex.branch_ne);
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= rs2_fwd;      // Forwarded, before the imm mux
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
        end
    end

endmodule

// ==== src/mem_wb_unit.sv ====
// Memory and writeback stages
// Word data memory, MEM/WB register, writeback select and retire strobe
`timescale 1ns/1ps

module mem_wb_unit (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::ex_mem_t   ex_mem,
    output rv_pkg::mem_wb_t   mem_wb,
    output rv_pkg::wb_event_t wb
);
    import rv_pkg::*;

    word_t              dmem [DMEM_WORDS] = '{default: '0};
    logic [DMEM_AW-1:0] dmem_idx;
    word_t              load_data;

    assign dmem_idx  = ex_mem.alu_result[DMEM_AW+1:2];
    assign load_data = dmem[dmem_idx];  // Combinational read

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            dmem[dmem_idx] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= load_data;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
        end
    end

    // Writes to x0 never show as retire events
    assign wb.valid = mem_wb.reg_write && mem_wb.rd != '0;
    assign wb.rd    = mem_wb.rd;
    assign wb.data  = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== src/pipe_ctrl.sv ====
// Pipeline control
// Load-use stall, branch flush and forwarding source select
`timescale 1ns/1ps

module pipe_ctrl (
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::reg_idx_t  rs1_idx,
    input  rv_pkg::reg_idx_t  rs2_idx,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::mem_wb_t   mem_wb,
    input  rv_pkg::redirect_t redirect,
    output rv_pkg::pipe_ctl_t ctl,
    output rv_pkg::fwd_sel_e  fwd_a,
    output rv_pkg::fwd_sel_e  fwd_b
);
    import rv_pkg::*;

    logic load_use;

    // Youngest producer wins
    function automatic fwd_sel_e pick_source(reg_idx_t rs);
        if (rs == '0) begin
            return FWD_REG;
        end
        if (ex_mem.reg_write && ex_mem.rd == rs) begin
            return FWD_MEM;
        end
        if (mem_wb.reg_write && mem_wb.rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign load_use = id_ex.mem_to_reg && id_ex.rd != '0 &&
                      (id_ex.rd == rs1_idx || id_ex.rd == rs2_idx);

    always_comb begin
        ctl.fetch_hold   = load_use;
        ctl.flush_if_id  = redirect.taken;
        ctl.bubble_id_ex = load_use | redirect.taken;
        fwd_a            = pick_source(id_ex.rs1);
        fwd_b            = pick_source(id_ex.rs2);
    end

endmodule

// ==== src/rv_core.sv ====
// RV32I five-stage core
// Fetch, decode, execute, memory and writeback with forwarding,
// load-use stall and branch flush. Instruction memory sits outside
`timescale 1ns/1ps

module rv_core (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::wb_event_t wb
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    redirect_t redirect;
    pipe_ctl_t ctl;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     rs1_data;
    word_t     rs2_data;

    fetch_unit i_fetch (
        .clk       (clk),
        .reset     (reset),
        .ctl       (ctl),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id)
    );

    decode_unit i_decode (
        .clk      (clk),
        .reset    (reset),
        .if_id    (if_id),
        .ctl      (ctl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .id_ex    (id_ex)
    );

    reg_file i_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    execute_unit i_execute (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .wb_data  (wb.data),
        .redirect (redirect)
    );

    mem_wb_unit i_mem_wb (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .wb     (wb)
    );

    pipe_ctrl i_ctrl (
        .id_ex    (id_ex),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .redirect (redirect),
        .ctl      (ctl),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

endmodule

// ==== sim/rv_core_chk.sv ====
// Pipeline control checks
// Bound into the core. Watches the retire strobe and the stall and
// flush controls
`timescale 1ns/1ps

module rv_core_chk (
    input logic              clk,
    input logic              reset,
    input rv_pkg::wb_event_t wb,
    input rv_pkg::pipe_ctl_t ctl,
    input rv_pkg::redirect_t redirect
);

    logic [2:0]  since_reset;     // Saturates at 4
    int unsigned fail_count = 0;  // Failed assertions so far

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_reset <= '0;
        end else if (since_reset < 3'd4) begin
            since_reset <= since_reset + 3'd1;
        end
    end

    // ==============================
    // Assertions
    // ==============================
    a_no_x0_strobe: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> wb.rd != '0)
        else begin
            fail_count++;
            $error("Retire strobe seen with rd = x0");
        end

    // A load-use bubble is never followed by a second one
    a_single_stall: assert property (@(posedge clk) disable iff (reset)
        (ctl.bubble_id_ex && !redirect.taken) |=> !(ctl.bubble_id_ex && !redirect.taken))
        else begin
            fail_count++;
            $error("Load-use bubble held for two cycles");
        end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        since_reset < 3'd4 |-> !wb.valid)
        else begin
            fail_count++;
            $error("Retire strobe within four cycles of reset");
        end

endmodule

// ==== sim/rv_core_tb.sv ====
// Testbench for the RV32I core
// Builds a random program, runs it through an ISA model and compares
// every retired register write with the model's list
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int PROG_LEN       = 64;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 100;
    localparam int TAIL_CYCLES    = 10;

    logic      clk = 1'b0;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    wb_event_t wb;

    word_t    prog [PROG_LEN];
    word_t    model_regs [32];
    word_t    model_mem [DMEM_WORDS];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    int       exp_idx     = 0;
    int       cycle_count = 0;

    rv_core i_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb)
    );

    bind rv_core rv_core_chk i_chk (
        .clk      (clk),
        .reset    (reset),
        .wb       (wb),
        .ctl      (ctl),
        .redirect (redirect)
    );

    always #2 clk = ~clk;

    // ==============================
    // Encoders and reference model
    // ==============================
    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($urandom_range(0, 7));  // x0..x7 keeps hazards frequent
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t fetch_word(word_t addr);
        if (addr < PROG_LEN * 4) begin
            return prog[addr[7:2]];
        end
        return NOP_INSTR;  // Past the program end
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped on first failure");
    endtask

    task automatic check_value(string what, word_t got, word_t expected);
        if (got !== expected) begin
            abort_run($sformatf("[ERROR] %0d ns: %s of write %0d is %h, expected %h",
                                $time, what, exp_idx, got, expected));
        end
    endtask

    task automatic build_program();
        int          kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [7:0]  slot;
        logic [7:0]  store_slot;
        store_slot = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = $urandom_range(0, 99);
            f3   = 3'($urandom_range(0, 7));
            f7   = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            if (kind < 25) begin
                f7      = (f3 == 3'd0 || f3 == 3'd5) ? f7 : 7'h00;
                prog[i] = enc_r(f7, rand_reg(), rand_reg(), f3, rand_reg());
            end else if (kind < 50) begin
                imm = 12'($urandom_range(0, 4095));
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {(f3 == 3'd5) ? f7 : 7'h00, imm[4:0]};  // Shift amount form
                end
                prog[i] = enc_i(imm, rand_reg(), f3, rand_reg(), OP_IMM);
            end else if (kind < 65) begin
                slot = 8'($urandom_range(0, 255));
                if ($urandom_range(0, 1) == 1) begin
                    slot = store_slot;  // Read back the latest store
                end
                imm     = {2'b00, slot, 2'b00};
                prog[i] = enc_i(imm, 5'd0, 3'b010, rand_reg(), LOAD);
            end else if (kind < 80) begin
                store_slot = 8'($urandom_range(0, 255));
                imm        = {2'b00, store_slot, 2'b00};
                prog[i]    = enc_s(imm, rand_reg(), 5'd0);
            end else begin
                f3      = {2'b00, 1'($urandom_range(0, 1))};  // BEQ or BNE
                prog[i] = enc_b(13'(4 * $urandom_range(2, 6)), rand_reg(), rand_reg(), f3);
            end
        end
    endtask

    task automatic write_reg(reg_idx_t rd, word_t value);
        if (rd != '0) begin
            model_regs[rd] = value;
            exp_rd.push_back(rd);
            exp_data.push_back(value);
        end
    endtask

    // Sequential ISA execution, forward branches only so it ends
    task automatic run_model();
        word_t      pc;
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        logic [2:0] f3;
        logic       take;
        pc = '0;
        while (pc < PROG_LEN * 4) begin
            instr = prog[pc[7:2]];
            f3    = instr[14:12];
            a     = model_regs[instr[19:15]];
            b     = model_regs[instr[24:20]];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            take  = 1'b0;
            case (opcode_e'(instr[6:0]))
                OP:     write_reg(instr[11:7], alu_ref(f3, instr[30], a, b));
                OP_IMM: write_reg(instr[11:7], alu_ref(f3, instr[30] && f3 == 3'd5, a, imm_i));
                LOAD:   write_reg(instr[11:7], model_mem[8'((a + imm_i) >> 2)]);
                STORE:  model_mem[8'((a + imm_s) >> 2)] = b;
                BRANCH: take = f3[0] ? (a != b) : (a == b);
                default: begin
                end
            endcase
            pc = take ? pc + imm_b : pc + 32'd4;
        end
    endtask

    // ==============================
    // Stimulus and checking
    // ==============================
    initial begin
        imem_data = NOP_INSTR;
        forever begin
            @(posedge clk);
            #1;
            imem_data = fetch_word(imem_addr);  // PC is stable by now
        end
    end

    always @(negedge clk) begin
        if (!reset && wb.valid) begin
            if (exp_idx >= exp_rd.size()) begin
                abort_run($sformatf("Unexpected extra register write to x%0d at %0d ns",
                                    wb.rd, $time));
            end else begin
                check_value("rd", 32'(wb.rd), 32'(exp_rd[exp_idx]));
                check_value("data", wb.data, exp_data[exp_idx]);
                exp_idx++;
            end
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_chk.fail_count != 0) begin
            abort_run("A pipeline control assertion failed");
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (cycle_count >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timeout: only %0d of %0d register writes seen in %0d cycles",
                                    exp_idx, exp_rd.size(), TIMEOUT_CYCLES));
            end else begin
                cycle_count <= cycle_count + 1;
            end
        end
    end

    initial begin
        reset = 1'b1;
        void'($urandom(92450));
        model_regs = '{default: '0};
        model_mem  = '{default: '0};
        build_program();
        run_model();
        $display("Program expects %0d register writes", exp_rd.size());
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        while (exp_idx < exp_rd.size()) begin
            @(posedge clk);
        end
        repeat (TAIL_CYCLES) @(posedge clk);  // No stray strobes after the last one
        #1;
        if (i_dut.i_chk.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("A pipeline control assertion failed");
        end
    end

endmodule

// ==== rv_core.f ====
src/rv_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/pipe_ctrl.sv
src/rv_core.sv
sim/rv_core_chk.sv
sim/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the rv_core testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb -f rv_core.f \
    && ./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -q "^ALL TESTS PASSED$" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
